// File: verilog/sme_pkg.sv
package sme_pkg;

    // ====================
    // Sizes
    // ====================
    localparam int CHAR_W    = 8;
    localparam int STR_DEPTH = 32;
    localparam int PAT_DEPTH = 8;

    // ====================
    // Types
    // ====================
    typedef logic [CHAR_W-1:0] char_t;

    // Index into the string buffer
    typedef logic [$clog2(STR_DEPTH)-1:0] str_idx_t;

    // String length, or a position that may sit one past the last char
    typedef logic [$clog2(STR_DEPTH+1)-1:0] str_len_t;

    // Index into the pattern buffer
    typedef logic [$clog2(PAT_DEPTH)-1:0] pat_idx_t;

    // Pattern length
    typedef logic [$clog2(PAT_DEPTH+1)-1:0] pat_len_t;

    // ====================
    // Character codes
    // ====================
    // Start anchor
    localparam char_t CHAR_HAT    = 8'h5E;
    // End anchor
    localparam char_t CHAR_DOLLAR = 8'h24;
    // Any single char
    localparam char_t CHAR_DOT    = 8'h2E;
    // Word separator for both anchors
    localparam char_t CHAR_SPACE  = 8'h20;

endpackage

// File: verilog/char_buffer.sv
`timescale 1ns/1ps

module char_buffer
#(
    parameter int DEPTH = 32
)
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           wr_en,
    input  sme_pkg::char_t                 wr_data,
    input  logic [$clog2(DEPTH)-1:0]       rd_addr,
    output sme_pkg::char_t                 rd_data,
    output logic [$clog2(DEPTH+1)-1:0]     length
);

    sme_pkg::char_t mem [0:DEPTH-1];

    // High when the previous cycle wrote, so this write appends
    logic wr_prev;
    logic full;
    logic [$clog2(DEPTH)-1:0] wr_addr;

    assign full    = (length == DEPTH);
    assign wr_addr = wr_prev ? length[$clog2(DEPTH)-1:0] : '0;

    // A new sequence overwrites from index 0
    always_ff @(posedge clk)
    begin
        if (wr_en && (!wr_prev || !full))
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Append pointer doubles as the stored length
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_prev <= 1'b0;
            length  <= '0;
        end
        else
        begin
            wr_prev <= wr_en;
            if (wr_en)
            begin
                if (!wr_prev)
                    length <= 1;
                else if (!full)
                    length <= length + 1'b1;
            end
        end
    end

    assign rd_data = mem[rd_addr];

endmodule

// File: verilog/char_compare.sv
`timescale 1ns/1ps

module char_compare
(
    input  sme_pkg::char_t pat_char,
    input  sme_pkg::char_t str_char,
    input  logic           str_at_start,
    input  logic           str_at_end,
    output logic           step_ok,
    output logic           advance_str,
    output logic           read_prev
);

    logic is_hat;
    logic is_dollar;
    logic is_dot;
    logic str_is_space;

    // ====================
    // Classify
    // ====================
    assign is_hat       = (pat_char == sme_pkg::CHAR_HAT);
    assign is_dollar    = (pat_char == sme_pkg::CHAR_DOLLAR);
    assign is_dot       = (pat_char == sme_pkg::CHAR_DOT);
    assign str_is_space = (str_char == sme_pkg::CHAR_SPACE);

    // ====================
    // Step outcome
    // ====================
    always_comb
    begin
        step_ok     = 1'b0;
        advance_str = 1'b0;
        read_prev   = 1'b0;

        if (is_hat)
        begin
            // Looks one char back so str_char is the previous char
            read_prev = 1'b1;
            step_ok   = str_at_start || str_is_space;
        end
        else if (is_dollar)
        begin
            // Zero width check that leaves the space unconsumed
            step_ok = str_at_end || str_is_space;
        end
        else if (str_at_end)
        begin
            // Nothing left to consume
            step_ok = 1'b0;
        end
        else
        begin
            advance_str = 1'b1;
            if (is_dot)
                step_ok = 1'b1;
            else
                step_ok = (pat_char == str_char);
        end
    end

endmodule

// File: verilog/sme_ctrl.sv
`timescale 1ns/1ps

module sme_ctrl
(
    input  logic              clk,
    input  logic              reset,
    input  logic              is_string,
    input  logic              is_pattern,
    input  sme_pkg::str_len_t str_len,
    input  sme_pkg::pat_len_t pat_len,
    input  logic              step_ok,
    input  logic              advance_str,
    input  logic              read_prev,
    output logic              string_wr,
    output logic              pattern_wr,
    output sme_pkg::str_idx_t str_rd_addr,
    output sme_pkg::pat_idx_t pat_rd_addr,
    output logic              str_at_start,
    output logic              str_at_end,
    output logic              valid,
    output logic              match,
    output sme_pkg::str_idx_t match_index
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEARCH,
        ST_DONE
    } state_t;

    state_t state;

    logic pat_loaded;

    // Candidate start, current string position, current pattern position
    sme_pkg::str_len_t frame;
    sme_pkg::str_len_t str_pos;
    sme_pkg::pat_idx_t pat_pos;

    // First string position consumed in the current frame
    logic              first_seen;
    sme_pkg::str_idx_t first_idx;

    logic              pat_last;
    logic              frame_last;
    sme_pkg::str_len_t rd_pos;
    sme_pkg::str_idx_t hit_index;

    // ====================
    // Load gating
    // ====================
    assign string_wr  = is_string && (state == ST_IDLE);
    assign pattern_wr = is_pattern && (state == ST_IDLE);

    // ====================
    // Read side
    // ====================
    assign rd_pos       = read_prev ? (str_pos - 1'b1) : str_pos;
    assign str_rd_addr  = rd_pos[$bits(sme_pkg::str_idx_t)-1:0];
    assign pat_rd_addr  = pat_pos;
    assign str_at_start = (str_pos == '0);
    assign str_at_end   = (str_pos >= str_len);

    assign pat_last   = ((sme_pkg::pat_len_t'(pat_pos) + 1'b1) == pat_len);
    assign frame_last = (frame >= str_len);

    // Anchor-only patterns never consume, so they report the frame
    always_comb
    begin
        if (first_seen)
            hit_index = first_idx;
        else if (advance_str)
            hit_index = str_pos[$bits(sme_pkg::str_idx_t)-1:0];
        else
            hit_index = frame[$bits(sme_pkg::str_idx_t)-1:0];
    end

    assign valid = (state == ST_DONE);

    // ====================
    // FSM and pointers
    // ====================
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state       <= ST_IDLE;
            pat_loaded  <= 1'b0;
            frame       <= '0;
            str_pos     <= '0;
            pat_pos     <= '0;
            first_seen  <= 1'b0;
            first_idx   <= '0;
            match       <= 1'b0;
            match_index <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (pattern_wr)
                    begin
                        pat_loaded <= 1'b1;
                    end
                    else if (!is_string && pat_loaded)
                    begin
                        // Quiet cycle after a pattern starts the search at frame 0
                        state      <= ST_SEARCH;
                        pat_loaded <= 1'b0;
                        frame      <= '0;
                        str_pos    <= '0;
                        pat_pos    <= '0;
                        first_seen <= 1'b0;
                    end
                end
                ST_SEARCH:
                begin
                    if (step_ok)
                    begin
                        if (pat_last)
                        begin
                            state       <= ST_DONE;
                            match       <= 1'b1;
                            match_index <= hit_index;
                        end
                        else
                        begin
                            pat_pos <= pat_pos + 1'b1;
                            if (advance_str)
                            begin
                                str_pos <= str_pos + 1'b1;
                                if (!first_seen)
                                begin
                                    first_seen <= 1'b1;
                                    first_idx  <= str_pos[$bits(sme_pkg::str_idx_t)-1:0];
                                end
                            end
                        end
                    end
                    else if (frame_last)
                    begin
                        // Every start position tried
                        state       <= ST_DONE;
                        match       <= 1'b0;
                        match_index <= '0;
                    end
                    else
                    begin
                        // Slide the frame by one and restart the pattern
                        frame      <= frame + 1'b1;
                        str_pos    <= frame + 1'b1;
                        pat_pos    <= '0;
                        first_seen <= 1'b0;
                    end
                end
                ST_DONE:
                begin
                    // Valid lasts one cycle and strobes here are dropped
                    state <= ST_IDLE;
                    match <= 1'b0;
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: verilog/sme_top.sv
`timescale 1ns/1ps

module sme_top
(
    input  logic              clk,
    input  logic              reset,
    input  sme_pkg::char_t    chardata,
    input  logic              is_string,
    input  logic              is_pattern,
    output logic              valid,
    output logic              match,
    output sme_pkg::str_idx_t match_index
);

    // ====================
    // Internal wires
    // ====================
    logic              string_wr;
    logic              pattern_wr;
    sme_pkg::str_idx_t str_rd_addr;
    sme_pkg::pat_idx_t pat_rd_addr;
    sme_pkg::str_len_t str_len;
    sme_pkg::pat_len_t pat_len;
    sme_pkg::char_t    str_char;
    sme_pkg::char_t    pat_char;
    logic              str_at_start;
    logic              str_at_end;
    logic              step_ok;
    logic              advance_str;
    logic              read_prev;

    sme_ctrl ctrl0
    (
        .clk          (clk),
        .reset        (reset),
        .is_string    (is_string),
        .is_pattern   (is_pattern),
        .str_len      (str_len),
        .pat_len      (pat_len),
        .step_ok      (step_ok),
        .advance_str  (advance_str),
        .read_prev    (read_prev),
        .string_wr    (string_wr),
        .pattern_wr   (pattern_wr),
        .str_rd_addr  (str_rd_addr),
        .pat_rd_addr  (pat_rd_addr),
        .str_at_start (str_at_start),
        .str_at_end   (str_at_end),
        .valid        (valid),
        .match        (match),
        .match_index  (match_index)
    );

    // String storage
    char_buffer #(.DEPTH(sme_pkg::STR_DEPTH)) str_buf
    (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (string_wr),
        .wr_data (chardata),
        .rd_addr (str_rd_addr),
        .rd_data (str_char),
        .length  (str_len)
    );

    // Pattern storage
    char_buffer #(.DEPTH(sme_pkg::PAT_DEPTH)) pat_buf
    (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (pattern_wr),
        .wr_data (chardata),
        .rd_addr (pat_rd_addr),
        .rd_data (pat_char),
        .length  (pat_len)
    );

    char_compare cmp0
    (
        .pat_char     (pat_char),
        .str_char     (str_char),
        .str_at_start (str_at_start),
        .str_at_end   (str_at_end),
        .step_ok      (step_ok),
        .advance_str  (advance_str),
        .read_prev    (read_prev)
    );

endmodule

// File: include/sme_tb_tasks.svh
`ifndef SME_TB_TASKS_SVH
`define SME_TB_TASKS_SVH

// One string byte per cycle and the strobe drops after the last byte
task automatic load_string(input string s);
    int i;
    for (i = 0; i < s.len(); i++)
    begin
        @(posedge clk);
        #1;
        chardata  = s[i];
        is_string = 1'b1;
    end
    @(posedge clk);
    #1;
    is_string = 1'b0;
endtask

// Same timing as the string load
task automatic load_pattern(input string p);
    int i;
    for (i = 0; i < p.len(); i++)
    begin
        @(posedge clk);
        #1;
        chardata   = p[i];
        is_pattern = 1'b1;
    end
    @(posedge clk);
    #1;
    is_pattern = 1'b0;
endtask

// Outputs are sampled at the falling edge away from register updates
task automatic wait_result();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!valid && cycles < 200)
    begin
        @(negedge clk);
        cycles++;
    end
    assert (valid)
    else
    begin
        $display("Timeout: the DUT gave no valid pulse within 200 cycles");
        $display("test failed");
        $fatal(1, "search never finished");
    end
endtask

task automatic check_result(input string name, input bit exp_match, input int exp_idx);
    assert (match === exp_match)
    else
    begin
        $display("[FAIL] %0t %s: match %b, expected %b", $time, name, match, exp_match);
        $display("test failed");
        $fatal(1, "wrong match flag");
    end
    assert (match_index === sme_pkg::str_idx_t'(exp_idx))
    else
    begin
        $display("[FAIL] %0t %s: index %0d, expected %0d", $time, name, match_index, exp_idx);
        $display("test failed");
        $fatal(1, "wrong match index");
    end
endtask

`endif

// File: verif/sme_tb.sv
`timescale 1ns/1ps

module sme_tb;

    logic              clk;
    logic              reset;
    sme_pkg::char_t    chardata;
    logic              is_string;
    logic              is_pattern;
    logic              valid;
    logic              match;
    sme_pkg::str_idx_t match_index;

    sme_top dut0
    (
        .clk         (clk),
        .reset       (reset),
        .chardata    (chardata),
        .is_string   (is_string),
        .is_pattern  (is_pattern),
        .valid       (valid),
        .match       (match),
        .match_index (match_index)
    );

    always #5 clk = ~clk;

    `include "sme_tb_tasks.svh"

    // ====================
    // Reference model
    // ====================
    // Start index of the first fitting frame or -1 when none fits
    function automatic int ref_search(input string s, input string p);
        int f;
        int k;
        int pos;
        int first;
        bit ok;
        sme_pkg::char_t c;
        for (f = 0; f <= s.len(); f++)
        begin
            pos   = f;
            first = -1;
            ok    = 1'b1;
            for (k = 0; k < p.len() && ok; k++)
            begin
                c = p[k];
                if (c == sme_pkg::CHAR_HAT)
                    ok = (pos == 0) || (s[pos-1] == sme_pkg::CHAR_SPACE);
                else if (c == sme_pkg::CHAR_DOLLAR)
                    ok = (pos >= s.len()) || (s[pos] == sme_pkg::CHAR_SPACE);
                else if (pos >= s.len())
                    ok = 1'b0;
                else
                begin
                    // Dot and literal both eat one char
                    ok = (c == sme_pkg::CHAR_DOT) || (c == s[pos]);
                    if (first < 0)
                        first = pos;
                    pos++;
                end
            end
            if (ok)
                return (first < 0) ? f : first;
        end
        return -1;
    endfunction

    function automatic string pick_char(input string alphabet);
        int k;
        k = $urandom % alphabet.len();
        return alphabet.substr(k, k);
    endfunction

    // exp_idx of -1 stands for no match
    task automatic run_case(input string s, input string p, input bit new_string,
                            input int exp_idx);
        if (new_string)
            load_string(s);
        load_pattern(p);
        wait_result();
        check_result($sformatf("'%s' on '%s'", p, s), exp_idx >= 0,
                     (exp_idx >= 0) ? exp_idx : 0);
    endtask

    // ====================
    // Tests
    // ====================
    task automatic idle_after_reset();
        int i;
        for (i = 0; i < 10; i++)
        begin
            @(negedge clk);
            assert (!valid && !match)
            else
            begin
                $display("[FAIL] %0t valid=%b match=%b with nothing loaded", $time, valid, match);
                $display("test failed");
                $fatal(1, "output active after reset");
            end
        end
    endtask

    task automatic literal_cases();
        run_case("hello world", "wor", 1'b1, 6);
        run_case("hello world", "l.o", 1'b1, 2);
        run_case("hello world", "o w", 1'b1, 4);
        run_case("hello world", "xyz", 1'b1, -1);
        run_case("hello world", "w.x", 1'b1, -1);
    endtask

    task automatic start_anchor_cases();
        run_case("cab ab", "^ab", 1'b1, 4);
        run_case("ab cab", "^ab", 1'b1, 0);
        run_case("cab", "^ab", 1'b1, -1);
    endtask

    task automatic end_anchor_cases();
        run_case("abc ab", "ab$", 1'b1, 4);
        run_case("abab c", "ab$", 1'b1, 2);
        run_case("abc", "ab$", 1'b1, -1);
        run_case("xab ab", "^ab$", 1'b1, 4);
        // Anchor alone reports the frame where it holds
        run_case("ab cd", "$", 1'b1, 2);
    endtask

    task automatic kept_string_cases();
        int i;
        run_case("xxxxxxxxxxxxyz", "yz", 1'b1, 12);
        load_pattern("xy");
        // Strobes while the search runs must not reach either buffer
        for (i = 0; i < 3; i++)
        begin
            @(posedge clk);
            #1;
            chardata   = "q";
            is_string  = (i != 2);
            is_pattern = (i == 2);
        end
        @(posedge clk);
        #1;
        is_string  = 1'b0;
        is_pattern = 1'b0;
        wait_result();
        check_result("'xy' on kept string with strobes during search", 1'b1, 11);
        run_case("xxxxxxxxxxxxyz", "z", 1'b0, 13);
        run_case("xxxxxxxxxxxxyz", "q", 1'b0, -1);
    endtask

    // Anchors only at the pattern ends
    task automatic random_cases();
        string s;
        string p;
        int n;
        int i;
        int t;
        for (t = 0; t < 20; t++)
        begin
            s = "";
            n = 1 + $urandom % 20;
            for (i = 0; i < n; i++)
                s = {s, pick_char("ab ")};
            p = "";
            if ($urandom % 3 == 0)
                p = "^";
            n = 1 + $urandom % (sme_pkg::PAT_DEPTH - 2);
            for (i = 0; i < n; i++)
                p = {p, pick_char("ab .")};
            if ($urandom % 3 == 0)
                p = {p, "$"};
            run_case(s, p, 1'b1, ref_search(s, p));
        end
    endtask

    initial
    begin
        clk        = 1'b0;
        reset      = 1'b1;
        chardata   = '0;
        is_string  = 1'b0;
        is_pattern = 1'b0;
        void'($urandom(37));
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        idle_after_reset();
        literal_cases();
        start_anchor_cases();
        end_anchor_cases();
        kept_string_cases();
        random_cases();
        $display("test passed");
        $finish;
    end

endmodule

// File: sme.f
+incdir+include
verilog/sme_pkg.sv
verilog/char_buffer.sv
verilog/char_compare.sv
verilog/sme_ctrl.sv
verilog/sme_top.sv
verif/sme_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f sme.f --top-module sme_tb -o sme_sim
./obj_dir/sme_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "test failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"
